//--- sbox_pkg.sv
package sbox_pkg;

  localparam int SYMBOL_W   = 6;
  localparam int GF4_W      = 2;
  localparam int PIPE_DEPTH = 3;  // Input, core and output registers.

  typedef logic [SYMBOL_W-1:0] symbol_t;  // Polynomial basis element of GF(2^6).
  typedef logic [GF4_W-1:0]    gf4_t;     // GF(4) element in normal basis.

  // GF(2^6) as three GF(4) coordinates. The first member lands in the top bits,
  // so c0 occupies bits 1:0 as in the bit layout of the S-box datapath.
  typedef struct packed {
    gf4_t c2;
    gf4_t c1;
    gf4_t c0;
  } tower_t;

  typedef struct packed {
    logic    valid;
    symbol_t symbol;
  } beat_t;

  typedef struct packed {
    logic   valid;
    tower_t tower;
  } tower_beat_t;

  // Squaring in a normal basis is a rotation, which for two bits is a swap.
  function automatic gf4_t gf4_sq(gf4_t a);
    gf4_t b;
    b[0] = a[1];
    b[1] = a[0];
    return b;
  endfunction

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  // Normal-basis product. The cross term t is shared by both output bits.
  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    gf4_t c;
    t    = (a[0] & b[1]) ^ (a[1] & b[0]);
    c[0] = (a[1] & b[1]) ^ t;
    c[1] = (a[0] & b[0]) ^ t;
    return c;
  endfunction

  // Polynomial basis modulo x^6 + x^5 + x^4 + x^2 + 1 to tower basis.
  function automatic tower_t to_tower(symbol_t a);
    logic [SYMBOL_W-1:0] b;
    b[0] = a[0] ^ a[1] ^ a[3];
    b[1] = a[0] ^ a[3];
    b[2] = a[0] ^ a[3] ^ a[4];
    b[3] = a[0] ^ a[3] ^ a[5];
    b[4] = a[0];
    b[5] = a[0] ^ a[2] ^ a[5];
    return tower_t'(b);
  endfunction

  // Tower basis back to polynomial basis, the inverse of to_tower.
  function automatic symbol_t from_tower(tower_t t);
    logic [SYMBOL_W-1:0] a;
    symbol_t             b;
    a    = t;
    b[0] = a[4];
    b[1] = a[0] ^ a[1];
    b[2] = a[1] ^ a[3] ^ a[4] ^ a[5];
    b[3] = a[1] ^ a[4];
    b[4] = a[1] ^ a[2];
    b[5] = a[1] ^ a[3];
    return b;
  endfunction

endpackage

//--- sbox_input_stage.sv
module sbox_input_stage
  import sbox_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  beat_t       in_beat,
  output tower_beat_t tower_in
);

  tower_t converted;

  // The basis change is pure XOR logic ahead of the first register.
  assign converted = to_tower(in_beat.symbol);

  always_ff @(posedge clk) begin
    if (reset) begin
      tower_in <= '0;  // Data cleared too, so idle slots read as zero.
    end else begin
      tower_in.valid <= in_beat.valid;
      tower_in.tower <= converted;
    end
  end

  // An unknown strobe here would propagate down the whole pipeline.
  a_valid_known : assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(tower_in.valid)
  ) else $error("tower_in.valid is unknown after reset");

endmodule

//--- power40_core.sv
module power40_core
  import sbox_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  tower_beat_t tower_in,
  output tower_beat_t tower_out
);

  // Intermediate terms of the first half. Index digits name the coordinates
  // that take part, so p02 is the product of squares 0 and 2.
  typedef struct packed {
    gf4_t sq0;
    gf4_t sq1;
    gf4_t sq2;
    gf4_t p01;
    gf4_t p02;
    gf4_t p12;
    gf4_t s01;
    gf4_t s02;
    gf4_t s12;
  } first_half_t;

  first_half_t fh;
  tower_t      result;

  // First half: squares, their pairwise products and the coordinate sums.
  always_comb begin
    fh.sq0 = gf4_sq(tower_in.tower.c0);
    fh.sq1 = gf4_sq(tower_in.tower.c1);
    fh.sq2 = gf4_sq(tower_in.tower.c2);

    fh.p01 = gf4_mul(fh.sq0, fh.sq1);
    fh.p02 = gf4_mul(fh.sq0, fh.sq2);
    fh.p12 = gf4_mul(fh.sq1, fh.sq2);

    fh.s01 = gf4_add(tower_in.tower.c0, tower_in.tower.c1);
    fh.s02 = gf4_add(tower_in.tower.c0, tower_in.tower.c2);
    fh.s12 = gf4_add(tower_in.tower.c1, tower_in.tower.c2);
  end

  // Second half. Each result coordinate pairs a product with the sum of
  // the two coordinates that are not its own index.
  always_comb begin
    result.c0 = gf4_add(fh.p02, fh.s12);
    result.c1 = gf4_add(fh.p01, fh.s02);
    result.c2 = gf4_add(fh.p12, fh.s01);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tower_out <= '0;
    end else begin
      tower_out.valid <= tower_in.valid;  // Strobe rides along with its data.
      tower_out.tower <= result;
    end
  end

  a_valid_delay : assert property (
    @(posedge clk) disable iff (reset)
    tower_out.valid == $past(tower_in.valid)
  ) else $error("tower_out.valid is not tower_in.valid delayed by one cycle");

  // Zero has no nonzero power, so the map must keep it at zero.
  a_zero_fixed : assert property (
    @(posedge clk) disable iff (reset)
    tower_in.valid && (tower_in.tower == '0) |=> tower_out.tower == '0
  ) else $error("power map did not send the zero element to zero");

endmodule

//--- sbox_output_stage.sv
module sbox_output_stage
  import sbox_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  tower_beat_t tower_out,
  output beat_t       out_beat
);

  symbol_t converted;

  assign converted = from_tower(tower_out.tower);  // Back to the input basis.

  always_ff @(posedge clk) begin
    if (reset) begin
      out_beat <= '0;
    end else begin
      out_beat.valid  <= tower_out.valid;
      out_beat.symbol <= converted;
    end
  end

  // The reset edge itself must have left the output strobe low.
  a_idle_after_reset : assert property (
    @(posedge clk)
    $fell(reset) |-> !out_beat.valid
  ) else $error("out_beat.valid is high in the first cycle after reset");

endmodule

//--- sbox_power40.sv
module sbox_power40
  import sbox_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  beat_t in_beat,
  output beat_t out_beat
);

  tower_beat_t tower_in;   // Input stage to core.
  tower_beat_t tower_out;  // Core to output stage.

  sbox_input_stage u_input_stage (
    .clk      (clk),
    .reset    (reset),
    .in_beat  (in_beat),
    .tower_in (tower_in)
  );

  power40_core u_core (
    .clk       (clk),
    .reset     (reset),
    .tower_in  (tower_in),
    .tower_out (tower_out)
  );

  sbox_output_stage u_output_stage (
    .clk       (clk),
    .reset     (reset),
    .tower_out (tower_out),
    .out_beat  (out_beat)
  );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period.
  end

  // Reset is held for five rising edges and released on the fifth.
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- tb_sbox_power40.sv
module tb_sbox_power40
  import sbox_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic    valid;
    logic    in_order;
    symbol_t symbol;
    symbol_t expected;
  } expect_t;

  logic        clk;
  logic        reset;
  beat_t       in_beat;
  beat_t       out_beat;
  expect_t     exp_pipe [PIPE_DEPTH];
  logic [63:0] seen;
  logic [31:0] rng_state;
  int          sampled_count;
  int          received_count;
  int          in_order_count;
  int          max_in_flight;
  int          reset_edges;
  int          run_edges;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  sbox_power40 u_dut (
    .clk      (clk),
    .reset    (reset),
    .in_beat  (in_beat),
    .out_beat (out_beat)
  );

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first failed check.");
  endtask

  task automatic report_mismatch(string test, int expected, int actual);
    $display("FAIL %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
    stop_on_failure();
  endtask

  task automatic report_error(string what);
    $display("ERROR: %s", what);
    stop_on_failure();
  endtask

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // GF(4) in the normal basis {w, w^2}. Bit 0 is w, bit 1 is w^2, and 11 is one.
  function automatic int gf4_log(gf4_t a);
    case (a)
      2'b01:   return 1;
      2'b10:   return 2;
      default: return 0;
    endcase
  endfunction

  function automatic gf4_t gf4_times(gf4_t a, gf4_t b);
    int e;
    if (a == 2'b00 || b == 2'b00) return 2'b00;
    e = (gf4_log(a) + gf4_log(b)) % 3;
    case (e)
      0:       return 2'b11;
      1:       return 2'b01;
      default: return 2'b10;
    endcase
  endfunction

  // Products of tower basis elements b0 = beta, b1 = beta^4, b2 = beta^16,
  // where beta^3 + beta^2 + 1 = 0. Bit k of the mask selects b_k.
  function automatic logic [2:0] basis_product(int i, int j);
    if (i == j) begin
      case (i)
        0:       return 3'b100;
        1:       return 3'b001;
        default: return 3'b010;
      endcase
    end
    case (i + j)
      1:       return 3'b110;
      2:       return 3'b011;
      default: return 3'b101;
    endcase
  endfunction

  function automatic tower_t tower_times(tower_t x, tower_t y);
    gf4_t       a [3];
    gf4_t       b [3];
    gf4_t       r [3];
    gf4_t       p;
    logic [2:0] mask;
    tower_t     t;
    a[0] = x.c0;
    a[1] = x.c1;
    a[2] = x.c2;
    b[0] = y.c0;
    b[1] = y.c1;
    b[2] = y.c2;
    for (int k = 0; k < 3; k++) r[k] = 2'b00;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        p    = gf4_times(a[i], b[j]);
        mask = basis_product(i, j);
        for (int k = 0; k < 3; k++) begin
          if (mask[k]) r[k] = r[k] ^ p;
        end
      end
    end
    t.c0 = r[0];
    t.c1 = r[1];
    t.c2 = r[2];
    return t;
  endfunction

  function automatic tower_t tower_pow40(tower_t x);
    tower_t result;
    tower_t base;
    int     e;
    result = '1;  // The unit is b0 + b1 + b2.
    base   = x;
    e      = 40;
    while (e > 0) begin
      if (e % 2 == 1) result = tower_times(result, base);
      base = tower_times(base, base);
      e    = e / 2;
    end
    return result;
  endfunction

  // Each output bit is the parity of the input bits picked by its mask.
  function automatic tower_t poly_to_tower(symbol_t a);
    symbol_t b;
    b[0] = ^(a & 6'b001011);
    b[1] = ^(a & 6'b001001);
    b[2] = ^(a & 6'b011001);
    b[3] = ^(a & 6'b101001);
    b[4] = ^(a & 6'b000001);
    b[5] = ^(a & 6'b100101);
    return tower_t'(b);
  endfunction

  function automatic symbol_t tower_to_poly(tower_t t);
    symbol_t a;
    symbol_t b;
    a    = symbol_t'(t);
    b[0] = ^(a & 6'b010000);
    b[1] = ^(a & 6'b000011);
    b[2] = ^(a & 6'b111010);
    b[3] = ^(a & 6'b010010);
    b[4] = ^(a & 6'b000110);
    b[5] = ^(a & 6'b001010);
    return b;
  endfunction

  function automatic symbol_t sbox_ref(symbol_t x);
    return tower_to_poly(tower_pow40(poly_to_tower(x)));
  endfunction

  // Scoreboard. Expected beats age one slot per edge and meet out_beat
  // PIPE_DEPTH edges after the DUT sampled them.
  always @(posedge clk) begin
    expect_t entry;
    int      in_flight;
    if (reset) begin
      if (reset_edges > 0) begin
        assert (out_beat.valid === 1'b0)
          else report_mismatch("reset_strobe", 0, int'(out_beat.valid));
      end
      reset_edges++;
      run_edges = 0;
      for (int i = 0; i < PIPE_DEPTH; i++) exp_pipe[i] = '0;
    end else begin
      if (run_edges == 0) begin
        assert (out_beat.valid === 1'b0)
          else report_mismatch("first_cycle_strobe", 0, int'(out_beat.valid));
      end
      entry = exp_pipe[PIPE_DEPTH-1];
      assert (out_beat.valid === entry.valid)
        else report_mismatch("strobe", int'(entry.valid), int'(out_beat.valid));
      if (entry.valid) begin
        assert (out_beat.symbol === entry.expected)
          else report_mismatch("value", int'(entry.expected), int'(out_beat.symbol));
        if (entry.symbol == 6'd0) begin
          assert (out_beat.symbol === 6'd0)
            else report_mismatch("zero_maps_to_zero", 0, int'(out_beat.symbol));
        end
        if (entry.symbol == 6'd1) begin
          assert (out_beat.symbol === 6'd1)
            else report_mismatch("one_maps_to_one", 1, int'(out_beat.symbol));
        end
        if (entry.in_order) begin
          assert (!seen[out_beat.symbol])
            else report_error("an in-order output value appeared twice");
          seen[out_beat.symbol] = 1'b1;
          in_order_count++;
        end
        received_count++;
      end
      for (int i = PIPE_DEPTH - 1; i > 0; i--) exp_pipe[i] = exp_pipe[i-1];
      exp_pipe[0].valid    = in_beat.valid;
      exp_pipe[0].in_order = in_beat.valid && (sampled_count < 64);
      exp_pipe[0].symbol   = in_beat.symbol;
      exp_pipe[0].expected = sbox_ref(in_beat.symbol);
      if (in_beat.valid) sampled_count++;
      // Symbols held in the three pipeline registers of the DUT.
      in_flight = int'(u_dut.tower_in.valid) + int'(u_dut.tower_out.valid)
                + int'(out_beat.valid);
      if (in_flight > max_in_flight) max_in_flight = in_flight;
      run_edges++;
    end
  end

  task automatic wait_for_reset_release();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (reset !== 1'b0) begin
      if (cycles == 20) report_error("reset was never released");
      @(posedge clk);
      cycles++;
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (received_count != sampled_count) begin
      if (cycles == 10) report_error("results did not drain out of the pipeline");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic send_symbol(symbol_t s);
    in_beat.valid  <= 1'b1;
    in_beat.symbol <= s;
    @(posedge clk);
  endtask

  task automatic idle_cycles(int count);
    for (int n = 0; n < count; n++) begin
      in_beat.valid <= 1'b0;
      @(posedge clk);
    end
  endtask

  initial begin
    in_beat        = '0;
    seen           = '0;
    rng_state      = 32'h3491_c34d;
    sampled_count  = 0;
    received_count = 0;
    in_order_count = 0;
    max_in_flight  = 0;
    reset_edges    = 0;
    run_edges      = 0;
    wait_for_reset_release();

    for (int i = 0; i < 64; i++) send_symbol(symbol_t'(i));  // Back to back.

    for (int n = 0; n < 300; n++) begin
      rng_state = xorshift32(rng_state);
      idle_cycles(int'(rng_state[9:8]));
      send_symbol(rng_state[5:0]);
    end
    in_beat.valid <= 1'b0;
    wait_for_drain();

    assert (in_order_count == 64)
      else report_mismatch("permutation_count", 64, in_order_count);
    assert (&seen)
      else report_error("the in-order outputs do not cover all 64 symbols");
    assert (max_in_flight == PIPE_DEPTH)
      else report_mismatch("in_flight", PIPE_DEPTH, max_in_flight);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- tb.f
sbox_pkg.sv
sbox_input_stage.sv
power40_core.sv
sbox_output_stage.sv
sbox_power40.sv
tb_clock_gen.sv
tb_sbox_power40.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the exit status of this script.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator \
  --binary \
  --timing \
  --assert \
  --timescale 1ns/100ps \
  -j 0 \
  --top-module tb_sbox_power40 \
  -f tb.f \
  -o sim_sbox_power40

./obj_dir/sim_sbox_power40
